// File: riscv_v_pkg.sv
// Widths, scalar and vector types for the vector datapath
// OP-V opcode, funct3 and funct6 encodings
// ALU operation enum
`default_nettype none

package riscv_v_pkg;

    // SEW is fixed at 32
    localparam int RISCV_V_ELEN = 32;

    // OP-V major opcode
    localparam logic [6:0] RISCV_V_OPCODE = 7'b1010111;

    // Operand forms
    localparam logic [2:0] RISCV_V_F3_OPIVV = 3'b000;
    localparam logic [2:0] RISCV_V_F3_OPIVI = 3'b011;
    localparam logic [2:0] RISCV_V_F3_OPIVX = 3'b100;

    // Supported operations
    localparam logic [5:0] RISCV_V_F6_VADD  = 6'b000000;
    localparam logic [5:0] RISCV_V_F6_VSUB  = 6'b000010;
    localparam logic [5:0] RISCV_V_F6_VMINU = 6'b000100;
    localparam logic [5:0] RISCV_V_F6_VMAXU = 6'b000110;
    localparam logic [5:0] RISCV_V_F6_VAND  = 6'b001001;
    localparam logic [5:0] RISCV_V_F6_VOR   = 6'b001010;
    localparam logic [5:0] RISCV_V_F6_VXOR  = 6'b001011;
    localparam logic [5:0] RISCV_V_F6_VMV   = 6'b010111;

    typedef logic [31:0] riscv_instruction_t;

    // One scalar value or one element
    typedef logic [RISCV_V_ELEN-1:0] riscv_data_t;

    typedef logic [4:0] riscv_v_addr_t;

    // Raw simm5 field
    typedef logic [4:0] riscv_v_imm_t;

    typedef logic [7:0] riscv_v_vl_t;

    typedef enum logic [2:0] {
        ALU_ADD  = 3'd0,
        ALU_SUB  = 3'd1,
        ALU_AND  = 3'd2,
        ALU_OR   = 3'd3,
        ALU_XOR  = 3'd4,
        ALU_MINU = 3'd5,
        ALU_MAXU = 3'd6,
        ALU_MOVE = 3'd7
    } riscv_v_alu_op_e;

endpackage

`default_nettype wire

// File: riscv_v_ctrl.sv
// Field decoder for OP-V instructions
// ALU op, operand form flags, register addresses, legality
`default_nettype none

module riscv_v_ctrl (
    input  riscv_v_pkg::riscv_instruction_t instruction,
    input  logic                            instr_valid,
    output riscv_v_pkg::riscv_v_alu_op_e    op,
    output riscv_v_pkg::riscv_v_addr_t      vs1,
    output riscv_v_pkg::riscv_v_addr_t      vs2,
    output riscv_v_pkg::riscv_v_addr_t      vd,
    output riscv_v_pkg::riscv_v_imm_t       imm,
    output logic                            vm,
    output logic                            is_scalar,
    output logic                            is_imm,
    output logic                            legal,
    output logic                            illegal
);

    import riscv_v_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [5:0] funct6;
    logic       form_ok;
    logic       op_ok;

    // Standard vector arithmetic layout
    assign opcode = instruction[6:0];
    assign vd     = instruction[11:7];
    assign funct3 = instruction[14:12];
    assign vs1    = instruction[19:15];
    assign imm    = instruction[19:15];
    assign vs2    = instruction[24:20];
    assign vm     = instruction[25];
    assign funct6 = instruction[31:26];

    assign is_scalar = (funct3 == RISCV_V_F3_OPIVX);
    assign is_imm    = (funct3 == RISCV_V_F3_OPIVI);
    assign form_ok   = (funct3 == RISCV_V_F3_OPIVV) || is_scalar || is_imm;

    always_comb begin
        op    = ALU_ADD;
        op_ok = 1'b1;
        case (funct6)
            RISCV_V_F6_VADD:  op = ALU_ADD;
            RISCV_V_F6_VSUB:  op = ALU_SUB;
            RISCV_V_F6_VAND:  op = ALU_AND;
            RISCV_V_F6_VOR:   op = ALU_OR;
            RISCV_V_F6_VXOR:  op = ALU_XOR;
            RISCV_V_F6_VMINU: op = ALU_MINU;
            RISCV_V_F6_VMAXU: op = ALU_MAXU;
            RISCV_V_F6_VMV: begin
                op = ALU_MOVE;
                // Only vmv.v.x, which encodes vs2 as zero
                op_ok = is_scalar && (vs2 == '0);
            end
            default: begin
                op_ok = 1'b0;
            end
        endcase
    end

    assign legal = instr_valid && (opcode == RISCV_V_OPCODE) && form_ok && op_ok;

    // Anything valid that did not decode becomes a bubble
    assign illegal = instr_valid && !legal;

endmodule

`default_nettype wire

// File: riscv_v_csr.sv
// vl register
// Resets to VLMAX, external writes clamp to VLMAX
`default_nettype none

module riscv_v_csr #(
    parameter int VLEN = 128
) (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     wr_en,
    input  riscv_v_pkg::riscv_data_t wr_data,
    output riscv_v_pkg::riscv_v_vl_t vl
);

    import riscv_v_pkg::*;

    localparam int VLMAX = VLEN / RISCV_V_ELEN;

    riscv_v_vl_t vl_next;

    // Smaller of request and VLMAX
    always_comb begin
        if (wr_data > riscv_data_t'(VLMAX)) begin
            vl_next = riscv_v_vl_t'(VLMAX);
        end else begin
            vl_next = riscv_v_vl_t'(wr_data);
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            vl <= riscv_v_vl_t'(VLMAX);
        end else if (wr_en) begin
            vl <= vl_next;
        end
    end

endmodule

`default_nettype wire

// File: riscv_v_rf.sv
// Vector register file, 32 entries of VLEN bits
// Three operand reads, v0 mask read and a debug read, write-through
`default_nettype none

module riscv_v_rf #(
    parameter int VLEN = 128
) (
    input  logic                       clk,
    input  logic                       arst_n,
    input  riscv_v_pkg::riscv_v_addr_t rd_addr_a,
    input  riscv_v_pkg::riscv_v_addr_t rd_addr_b,
    input  riscv_v_pkg::riscv_v_addr_t rd_addr_d,
    output logic [VLEN-1:0]            rd_data_a,
    output logic [VLEN-1:0]            rd_data_b,
    output logic [VLEN-1:0]            rd_data_d,
    output logic [VLEN-1:0]            mask,
    input  logic                       wr_en,
    input  riscv_v_pkg::riscv_v_addr_t wr_addr,
    input  logic [VLEN-1:0]            wr_data,
    input  riscv_v_pkg::riscv_v_addr_t dbg_addr,
    output logic [VLEN-1:0]            dbg_data
);

    localparam int NUM_REGS = 32;

    logic [VLEN-1:0] regs [NUM_REGS];

    // All registers clear on reset
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // Same-cycle write shows on every read
    assign rd_data_a = (wr_en && (wr_addr == rd_addr_a)) ? wr_data : regs[rd_addr_a];
    assign rd_data_b = (wr_en && (wr_addr == rd_addr_b)) ? wr_data : regs[rd_addr_b];
    assign rd_data_d = (wr_en && (wr_addr == rd_addr_d)) ? wr_data : regs[rd_addr_d];
    assign dbg_data  = (wr_en && (wr_addr == dbg_addr)) ? wr_data : regs[dbg_addr];

    assign mask = (wr_en && (wr_addr == '0)) ? wr_data : regs[0];

endmodule

`default_nettype wire

// File: riscv_v_decode.sv
// Vector ID stage
// Field decode, vl CSR, register file, EXE forwarding, ID/EXE register
`default_nettype none

module riscv_v_decode #(
    parameter int VLEN = 128
) (
    input  logic                                   clk,
    input  logic                                   arst_n,
    input  logic                                   clear_pipe,
    input  logic                                   riscv_stall,
    input  riscv_v_pkg::riscv_instruction_t        instruction,
    input  logic                                   instr_valid,
    input  riscv_v_pkg::riscv_data_t               scalar_data,
    input  logic                                   ext_wr_vl,
    input  riscv_v_pkg::riscv_data_t               ext_vl_data,
    input  riscv_v_pkg::riscv_v_addr_t             dbg_addr,
    output logic [VLEN-1:0]                        dbg_data,
    input  logic                                   fwd_valid,
    input  riscv_v_pkg::riscv_v_addr_t             fwd_vd,
    input  logic [VLEN-1:0]                        fwd_data,
    input  logic                                   wb_valid,
    input  riscv_v_pkg::riscv_v_addr_t             wb_vd,
    input  logic [VLEN-1:0]                        wb_data,
    output logic                                   exe_valid,
    output riscv_v_pkg::riscv_v_alu_op_e           exe_op,
    output riscv_v_pkg::riscv_v_addr_t             exe_vd,
    output logic                                   exe_vm,
    output logic [VLEN-1:0]                        exe_srca,
    output logic [VLEN-1:0]                        exe_srcb,
    output logic [VLEN-1:0]                        exe_old_vd,
    output logic [VLEN/riscv_v_pkg::RISCV_V_ELEN-1:0] exe_mask,
    output riscv_v_pkg::riscv_v_vl_t               exe_vl,
    output logic                                   illegal,
    output riscv_v_pkg::riscv_v_vl_t               vl
);

    import riscv_v_pkg::*;

    localparam int LANES = VLEN / RISCV_V_ELEN;

    riscv_v_alu_op_e op;
    riscv_v_addr_t   vs1;
    riscv_v_addr_t   vs2;
    riscv_v_addr_t   vd;
    riscv_v_imm_t    imm;
    logic            vm;
    logic            is_scalar;
    logic            is_imm;
    logic            legal;
    logic            dec_illegal;
    logic            rf_wr_en;
    riscv_data_t     imm_ext;
    logic [VLEN-1:0] rf_a;
    logic [VLEN-1:0] rf_b;
    logic [VLEN-1:0] rf_d;
    logic [VLEN-1:0] rf_mask;
    logic [VLEN-1:0] src_a;
    logic [VLEN-1:0] src_b;
    logic [VLEN-1:0] old_vd;
    logic [VLEN-1:0] mask_full;

    riscv_v_ctrl i_riscv_v_ctrl (
        .instruction (instruction),
        .instr_valid (instr_valid),
        .op          (op),
        .vs1         (vs1),
        .vs2         (vs2),
        .vd          (vd),
        .imm         (imm),
        .vm          (vm),
        .is_scalar   (is_scalar),
        .is_imm      (is_imm),
        .legal       (legal),
        .illegal     (dec_illegal)
    );

    riscv_v_csr #(
        .VLEN (VLEN)
    ) i_riscv_v_csr (
        .clk     (clk),
        .arst_n  (arst_n),
        .wr_en   (ext_wr_vl),
        .wr_data (ext_vl_data),
        .vl      (vl)
    );

    // WB write is held back while the pipe is frozen
    assign rf_wr_en = wb_valid && !riscv_stall;

    riscv_v_rf #(
        .VLEN (VLEN)
    ) i_riscv_v_rf (
        .clk       (clk),
        .arst_n    (arst_n),
        .rd_addr_a (vs1),
        .rd_addr_b (vs2),
        .rd_addr_d (vd),
        .rd_data_a (rf_a),
        .rd_data_b (rf_b),
        .rd_data_d (rf_d),
        .mask      (rf_mask),
        .wr_en     (rf_wr_en),
        .wr_addr   (wb_vd),
        .wr_data   (wb_data),
        .dbg_addr  (dbg_addr),
        .dbg_data  (dbg_data)
    );

    // Forwarded EXE result takes priority over the register file
    assign src_b     = (fwd_valid && (fwd_vd == vs2)) ? fwd_data : rf_b;
    assign old_vd    = (fwd_valid && (fwd_vd == vd)) ? fwd_data : rf_d;
    assign mask_full = (fwd_valid && (fwd_vd == '0)) ? fwd_data : rf_mask;

    assign imm_ext = {{(RISCV_V_ELEN-5){imm[4]}}, imm};

    // Scalar and immediate forms splat across all lanes
    always_comb begin
        if (is_scalar) begin
            src_a = {LANES{scalar_data}};
        end else if (is_imm) begin
            src_a = {LANES{imm_ext}};
        end else if (fwd_valid && (fwd_vd == vs1)) begin
            src_a = fwd_data;
        end else begin
            src_a = rf_a;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            exe_valid <= 1'b0;
            illegal   <= 1'b0;
        end else if (clear_pipe) begin
            exe_valid <= 1'b0;
            illegal   <= 1'b0;
        end else if (!riscv_stall) begin
            exe_valid <= legal;
            illegal   <= dec_illegal;
        end else begin
            illegal   <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!riscv_stall) begin
            exe_op     <= op;
            exe_vd     <= vd;
            exe_vm     <= vm;
            exe_srca   <= src_a;
            exe_srcb   <= src_b;
            exe_old_vd <= old_vd;
            exe_mask   <= mask_full[LANES-1:0];
            exe_vl     <= vl;
        end
    end

endmodule

`default_nettype wire

// File: riscv_v_exe.sv
// Vector EXE stage
// Per-lane 32-bit ALU, mask and tail merge, EXE/WB register
`default_nettype none

module riscv_v_exe #(
    parameter int VLEN = 128
) (
    input  logic                                      clk,
    input  logic                                      arst_n,
    input  logic                                      clear_pipe,
    input  logic                                      riscv_stall,
    input  logic                                      exe_valid,
    input  riscv_v_pkg::riscv_v_alu_op_e              exe_op,
    input  riscv_v_pkg::riscv_v_addr_t                exe_vd,
    input  logic                                      exe_vm,
    input  logic [VLEN-1:0]                           exe_srca,
    input  logic [VLEN-1:0]                           exe_srcb,
    input  logic [VLEN-1:0]                           exe_old_vd,
    input  logic [VLEN/riscv_v_pkg::RISCV_V_ELEN-1:0] exe_mask,
    input  riscv_v_pkg::riscv_v_vl_t                  exe_vl,
    output logic                                      fwd_valid,
    output riscv_v_pkg::riscv_v_addr_t                fwd_vd,
    output logic [VLEN-1:0]                           fwd_data,
    output logic                                      wb_valid,
    output riscv_v_pkg::riscv_v_addr_t                wb_vd,
    output logic [VLEN-1:0]                           wb_data
);

    import riscv_v_pkg::*;

    localparam int LANES = VLEN / RISCV_V_ELEN;

    logic [VLEN-1:0] result;

    for (genvar i = 0; i < LANES; i++) begin : g_lane
        riscv_data_t a;
        riscv_data_t b;
        riscv_data_t old;
        riscv_data_t alu;
        logic        keep;

        assign a   = exe_srca[i*RISCV_V_ELEN +: RISCV_V_ELEN];
        assign b   = exe_srcb[i*RISCV_V_ELEN +: RISCV_V_ELEN];
        assign old = exe_old_vd[i*RISCV_V_ELEN +: RISCV_V_ELEN];

        // vs2 is the left operand
        always_comb begin
            case (exe_op)
                ALU_ADD:  alu = b + a;
                ALU_SUB:  alu = b - a;
                ALU_AND:  alu = b & a;
                ALU_OR:   alu = b | a;
                ALU_XOR:  alu = b ^ a;
                ALU_MINU: alu = (b < a) ? b : a;
                ALU_MAXU: alu = (b > a) ? b : a;
                default:  alu = a;
            endcase
        end

        // Tail and masked-off lanes are undisturbed
        assign keep = (riscv_v_vl_t'(i) >= exe_vl) || (!exe_vm && !exe_mask[i]);

        assign result[i*RISCV_V_ELEN +: RISCV_V_ELEN] = keep ? old : alu;
    end

    assign fwd_valid = exe_valid;
    assign fwd_vd    = exe_vd;
    assign fwd_data  = result;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_valid <= 1'b0;
        end else if (clear_pipe) begin
            wb_valid <= 1'b0;
        end else if (!riscv_stall) begin
            wb_valid <= exe_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!riscv_stall) begin
            wb_vd   <= exe_vd;
            wb_data <= result;
        end
    end

endmodule

`default_nettype wire

// File: riscv_v_core.sv
// Vector datapath top level
// Decode stage feeding the execute stage, WB closes the loop
`default_nettype none

module riscv_v_core #(
    parameter int VLEN = 128
) (
    input  logic                            clk,
    input  logic                            arst_n,
    input  riscv_v_pkg::riscv_instruction_t instruction,
    input  logic                            instr_valid,
    input  riscv_v_pkg::riscv_data_t        scalar_data,
    input  logic                            riscv_stall,
    input  logic                            clear_pipe,
    input  logic                            ext_wr_vl,
    input  riscv_v_pkg::riscv_data_t        ext_vl_data,
    input  riscv_v_pkg::riscv_v_addr_t      dbg_addr,
    output logic                            wb_valid,
    output riscv_v_pkg::riscv_v_addr_t      wb_vd,
    output logic                            illegal,
    output riscv_v_pkg::riscv_v_vl_t        vl,
    output logic [VLEN-1:0]                 dbg_data
);

    import riscv_v_pkg::*;

    localparam int LANES = VLEN / RISCV_V_ELEN;

    logic            exe_valid;
    riscv_v_alu_op_e exe_op;
    riscv_v_addr_t   exe_vd;
    logic            exe_vm;
    logic [VLEN-1:0] exe_srca;
    logic [VLEN-1:0] exe_srcb;
    logic [VLEN-1:0] exe_old_vd;
    logic [LANES-1:0] exe_mask;
    riscv_v_vl_t     exe_vl;
    logic            fwd_valid;
    riscv_v_addr_t   fwd_vd;
    logic [VLEN-1:0] fwd_data;
    logic [VLEN-1:0] wb_data;

    riscv_v_decode #(
        .VLEN (VLEN)
    ) i_riscv_v_decode (
        .clk         (clk),
        .arst_n      (arst_n),
        .clear_pipe  (clear_pipe),
        .riscv_stall (riscv_stall),
        .instruction (instruction),
        .instr_valid (instr_valid),
        .scalar_data (scalar_data),
        .ext_wr_vl   (ext_wr_vl),
        .ext_vl_data (ext_vl_data),
        .dbg_addr    (dbg_addr),
        .dbg_data    (dbg_data),
        .fwd_valid   (fwd_valid),
        .fwd_vd      (fwd_vd),
        .fwd_data    (fwd_data),
        .wb_valid    (wb_valid),
        .wb_vd       (wb_vd),
        .wb_data     (wb_data),
        .exe_valid   (exe_valid),
        .exe_op      (exe_op),
        .exe_vd      (exe_vd),
        .exe_vm      (exe_vm),
        .exe_srca    (exe_srca),
        .exe_srcb    (exe_srcb),
        .exe_old_vd  (exe_old_vd),
        .exe_mask    (exe_mask),
        .exe_vl      (exe_vl),
        .illegal     (illegal),
        .vl          (vl)
    );

    riscv_v_exe #(
        .VLEN (VLEN)
    ) i_riscv_v_exe (
        .clk         (clk),
        .arst_n      (arst_n),
        .clear_pipe  (clear_pipe),
        .riscv_stall (riscv_stall),
        .exe_valid   (exe_valid),
        .exe_op      (exe_op),
        .exe_vd      (exe_vd),
        .exe_vm      (exe_vm),
        .exe_srca    (exe_srca),
        .exe_srcb    (exe_srcb),
        .exe_old_vd  (exe_old_vd),
        .exe_mask    (exe_mask),
        .exe_vl      (exe_vl),
        .fwd_valid   (fwd_valid),
        .fwd_vd      (fwd_vd),
        .fwd_data    (fwd_data),
        .wb_valid    (wb_valid),
        .wb_vd       (wb_vd),
        .wb_data     (wb_data)
    );

endmodule

`default_nettype wire

// File: tb_riscv_v_core.sv
// Directed testbench for the vector datapath core
// Shadow register model, pipeline timing checks, watchdog
`default_nettype none

module tb_riscv_v_core;

    import riscv_v_pkg::*;

    localparam int VLEN          = 128;
    localparam int LANES         = VLEN / RISCV_V_ELEN;
    localparam int CLK_PERIOD    = 100;
    localparam int DRIVE_DELAY   = 10;
    localparam int SAMPLE_DELAY  = 40;
    // Instructions issued by all tests together
    localparam int INSTR_BUDGET  = 1 + 6 * 4 + 7 * 3 + 3 * 3 + 3 + 2 + 2;
    localparam int MARGIN_CYCLES = 200;

    localparam logic [5:0] ALU_F6 [7] = '{
        RISCV_V_F6_VADD, RISCV_V_F6_VSUB, RISCV_V_F6_VAND, RISCV_V_F6_VOR,
        RISCV_V_F6_VXOR, RISCV_V_F6_VMINU, RISCV_V_F6_VMAXU
    };
    localparam logic [2:0] FORMS [3] = '{
        RISCV_V_F3_OPIVV, RISCV_V_F3_OPIVX, RISCV_V_F3_OPIVI
    };

    logic               clk;
    logic               arst_n;
    riscv_instruction_t instruction;
    logic               instr_valid;
    riscv_data_t        scalar_data;
    logic               riscv_stall;
    logic               clear_pipe;
    logic               ext_wr_vl;
    riscv_data_t        ext_vl_data;
    riscv_v_addr_t      dbg_addr;
    logic               wb_valid;
    riscv_v_addr_t      wb_vd;
    logic               illegal;
    riscv_v_vl_t        vl;
    logic [VLEN-1:0]    dbg_data;

    // Expected register contents, lane by lane
    logic [31:0] shadow [32][4];
    logic [7:0]  shadow_vl;
    int          errors;
    int          seed;

    riscv_v_core #(
        .VLEN (VLEN)
    ) i_riscv_v_core (
        .clk         (clk),
        .arst_n      (arst_n),
        .instruction (instruction),
        .instr_valid (instr_valid),
        .scalar_data (scalar_data),
        .riscv_stall (riscv_stall),
        .clear_pipe  (clear_pipe),
        .ext_wr_vl   (ext_wr_vl),
        .ext_vl_data (ext_vl_data),
        .dbg_addr    (dbg_addr),
        .wb_valid    (wb_valid),
        .wb_vd       (wb_vd),
        .illegal     (illegal),
        .vl          (vl),
        .dbg_data    (dbg_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #((INSTR_BUDGET * 10 + MARGIN_CYCLES) * CLK_PERIOD);
        $display("Timeout: the tests did not finish within the time limit");
        $display("Error count: %0d", errors);
        $display("Checks failed");
        $finish;
    end

    function automatic logic [31:0] encode(input logic [5:0] f6, input logic [2:0] f3,
                                           input logic [4:0] vd, input logic [4:0] src1,
                                           input logic [4:0] vs2, input logic vm);
        return {f6, vm, vs2, src1, f3, vd, RISCV_V_OPCODE};
    endfunction

    // vs2 is the left operand, a is vs1, scalar or immediate
    function automatic logic [31:0] alu_model(input logic [5:0] f6, input logic [31:0] b,
                                              input logic [31:0] a);
        case (f6)
            RISCV_V_F6_VADD:  return b + a;
            RISCV_V_F6_VSUB:  return b - a;
            RISCV_V_F6_VAND:  return b & a;
            RISCV_V_F6_VOR:   return b | a;
            RISCV_V_F6_VXOR:  return b ^ a;
            RISCV_V_F6_VMINU: return (b < a) ? b : a;
            RISCV_V_F6_VMAXU: return (b > a) ? b : a;
            default:          return a;
        endcase
    endfunction

    task automatic expect_eq(input string name, input logic [127:0] exp, input logic [127:0] act);
        assert (act === exp) else begin
            errors++;
            $display("CHECK FAILED time=%0t signal=%s expected=%h actual=%h",
                     $time, name, exp, act);
        end
    endtask

    task automatic next_cycle;
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic idle(input int n);
        repeat (n) next_cycle();
    endtask

    // Three stages, so four idle cycles retire everything in flight
    task automatic drain;
        idle(4);
    endtask

    task automatic issue(input logic [31:0] instr, input logic [31:0] xval);
        instruction = instr;
        scalar_data = xval;
        instr_valid = 1'b1;
        next_cycle();
        instr_valid = 1'b0;
    endtask

    task automatic write_vl(input logic [31:0] n);
        ext_wr_vl   = 1'b1;
        ext_vl_data = n;
        next_cycle();
        ext_wr_vl   = 1'b0;
        shadow_vl   = (n > 32'(LANES)) ? 8'(LANES) : n[7:0];
    endtask

    task automatic execute(input logic [5:0] f6, input logic [2:0] f3, input logic [4:0] vd,
                           input logic [4:0] src1, input logic [4:0] vs2, input logic vm,
                           input logic [31:0] xval);
        logic [31:0] a;
        logic [31:0] res [4];
        for (int i = 0; i < 4; i++) begin
            if (f3 == RISCV_V_F3_OPIVV) begin
                a = shadow[src1][i];
            end else if (f3 == RISCV_V_F3_OPIVX) begin
                a = xval;
            end else begin
                a = {{27{src1[4]}}, src1};
            end
            // Tail and masked-off lanes keep the old value
            if ((i < int'(shadow_vl)) && (vm || shadow[0][0][i])) begin
                res[i] = alu_model(f6, shadow[vs2][i], a);
            end else begin
                res[i] = shadow[vd][i];
            end
        end
        for (int i = 0; i < 4; i++) begin
            shadow[vd][i] = res[i];
        end
        issue(encode(f6, f3, vd, src1, vs2, vm), xval);
    endtask

    task automatic check_reg(input logic [4:0] r);
        dbg_addr = r;
        #SAMPLE_DELAY;
        expect_eq($sformatf("dbg_data v%0d", r),
                  {shadow[r][3], shadow[r][2], shadow[r][1], shadow[r][0]}, 128'(dbg_data));
        next_cycle();
    endtask

    // Cycle 0 is the one right after the issue cycle
    // A cycle number of -1 means never
    task automatic watch_pipe(input int ncycles, input int wb_cycle, input logic [4:0] vd,
                              input int illegal_cycle);
        for (int k = 0; k < ncycles; k++) begin
            #SAMPLE_DELAY;
            expect_eq("illegal", 128'(k == illegal_cycle), 128'(illegal));
            expect_eq("wb_valid", 128'(k == wb_cycle), 128'(wb_valid));
            if (k == wb_cycle) begin
                expect_eq("wb_vd", 128'(vd), 128'(wb_vd));
            end
            next_cycle();
        end
    endtask

    // Different value per lane through shrinking vl
    task automatic load_reg(input logic [4:0] r);
        for (int k = 0; k < 4; k++) begin
            write_vl(32'(4 - k));
            execute(RISCV_V_F6_VMV, RISCV_V_F3_OPIVX, r, 5'd0, 5'd0, 1'b1, $random(seed));
        end
        write_vl(32'(LANES));
        drain();
    endtask

    task automatic reset_and_broadcast;
        #SAMPLE_DELAY;
        expect_eq("vl", 128'(LANES), 128'(vl));
        next_cycle();
        for (int r = 0; r < 32; r++) begin
            check_reg(5'(r));
        end
        execute(RISCV_V_F6_VMV, RISCV_V_F3_OPIVX, 5'd1, 5'd0, 5'd0, 1'b1, 32'hdead_beef);
        drain();
        check_reg(5'd1);
    endtask

    task automatic alu_forms;
        logic [31:0] rnd;
        logic [4:0]  vs1;
        logic [4:0]  vs2;
        logic [4:0]  imm;
        for (int k = 0; k < 7; k++) begin
            for (int f = 0; f < 3; f++) begin
                rnd = $random(seed);
                vs1 = 5'(rnd[7:0] % 8'd6) + 5'd1;
                vs2 = 5'(rnd[15:8] % 8'd6) + 5'd1;
                // Even ops get a negative immediate
                imm = (k % 2 == 0) ? 5'b10110 : rnd[20:16];
                execute(ALU_F6[k], FORMS[f], 5'd20, (f == 2) ? imm : vs1, vs2, 1'b1,
                        $random(seed));
                drain();
                check_reg(5'd20);
            end
        end
    endtask

    task automatic dependent_chains;
        for (int d = 1; d <= 3; d++) begin
            // vl of 3 makes lane 3 depend on the forwarded old vd
            write_vl(32'd3);
            execute(RISCV_V_F6_VADD, RISCV_V_F3_OPIVV, 5'd12, 5'd1, 5'd2, 1'b1, 32'd0);
            idle(d - 1);
            execute(RISCV_V_F6_VSUB, RISCV_V_F3_OPIVV, 5'd13, 5'd3, 5'd12, 1'b1, 32'd0);
            idle(d - 1);
            execute(RISCV_V_F6_VXOR, RISCV_V_F3_OPIVV, 5'd12, 5'd13, 5'd12, 1'b1, 32'd0);
            write_vl(32'(LANES));
            drain();
            check_reg(5'd12);
            check_reg(5'd13);
        end
    endtask

    task automatic mask_and_tail;
        // v0 low bits 0101 enable lanes 0 and 2
        execute(RISCV_V_F6_VMV, RISCV_V_F3_OPIVX, 5'd0, 5'd0, 5'd0, 1'b1, 32'h5);
        execute(RISCV_V_F6_VADD, RISCV_V_F3_OPIVV, 5'd5, 5'd2, 5'd3, 1'b0, 32'd0);
        drain();
        check_reg(5'd5);
        write_vl(32'd2);
        #SAMPLE_DELAY;
        expect_eq("vl", 128'(shadow_vl), 128'(vl));
        next_cycle();
        execute(RISCV_V_F6_VSUB, RISCV_V_F3_OPIVV, 5'd6, 5'd2, 5'd3, 1'b1, 32'd0);
        write_vl(32'd9);
        #SAMPLE_DELAY;
        expect_eq("vl", 128'(LANES), 128'(vl));
        next_cycle();
        drain();
        check_reg(5'd6);
    endtask

    task automatic illegal_and_wb_timing;
        issue(encode(6'b111111, RISCV_V_F3_OPIVV, 5'd7, 5'd1, 5'd2, 1'b1), 32'd0);
        watch_pipe(4, -1, 5'd0, 0);
        check_reg(5'd7);
        execute(RISCV_V_F6_VOR, RISCV_V_F3_OPIVX, 5'd8, 5'd0, 5'd3, 1'b1, $random(seed));
        watch_pipe(3, 1, 5'd8, -1);
        check_reg(5'd8);
    endtask

    task automatic stall_and_flush;
        execute(RISCV_V_F6_VADD, RISCV_V_F3_OPIVX, 5'd10, 5'd0, 5'd1, 1'b1, $random(seed));
        riscv_stall = 1'b1;
        watch_pipe(3, -1, 5'd0, -1);
        riscv_stall = 1'b0;
        watch_pipe(4, 1, 5'd10, -1);
        check_reg(5'd10);
        // Not applied to the model since clear_pipe cancels it
        issue(encode(RISCV_V_F6_VADD, RISCV_V_F3_OPIVV, 5'd11, 5'd1, 5'd2, 1'b1), 32'd0);
        clear_pipe = 1'b1;
        watch_pipe(1, -1, 5'd0, -1);
        clear_pipe = 1'b0;
        watch_pipe(3, -1, 5'd0, -1);
        check_reg(5'd11);
    endtask

    initial begin
        arst_n      = 1'b0;
        instruction = '0;
        instr_valid = 1'b0;
        scalar_data = '0;
        riscv_stall = 1'b0;
        clear_pipe  = 1'b0;
        ext_wr_vl   = 1'b0;
        ext_vl_data = '0;
        dbg_addr    = '0;
        errors      = 0;
        seed        = 32'h6705_c3a9;
        shadow_vl   = 8'(LANES);
        for (int r = 0; r < 32; r++) begin
            for (int i = 0; i < 4; i++) begin
                shadow[r][i] = '0;
            end
        end
        repeat (10) @(posedge clk);
        #DRIVE_DELAY;
        arst_n = 1'b1;

        reset_and_broadcast();
        for (int r = 1; r <= 6; r++) begin
            load_reg(5'(r));
        end
        alu_forms();
        dependent_chains();
        mask_and_tail();
        illegal_and_wb_timing();
        stall_and_flush();

        $display("Error count: %0d", errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
riscv_v_pkg.sv
riscv_v_ctrl.sv
riscv_v_csr.sv
riscv_v_rf.sv
riscv_v_decode.sv
riscv_v_exe.sv
riscv_v_core.sv
tb_riscv_v_core.sv

// File: run.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f vlog.f --top-module tb_riscv_v_core -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with an error"
    exit 1
fi

if printf '%s\n' "$out" | grep -q "^All checks passed$"; then
    exit 0
fi
exit 1
